// File: vlog.f
source/csr_pkg.sv
source/ctrl_pkg.sv
source/csr_irq_regs.sv
source/int_controller.sv
source/sleep_unit.sv
source/alert_unit.sv
source/hart_ctrl_top.sv
test/tb_clock_gen.sv
test/tb_hart_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the hart control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_hart_ctrl

# Simulation output kept in a variable, no log file
out=$(./obj_dir/Vtb_hart_ctrl)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
else
  exit 1
fi

// File: test/tb_hart_ctrl.sv
`default_nettype none

module tb_hart_ctrl;

  import csr_pkg::*;
  import ctrl_pkg::*;

  localparam int WAIT_LIMIT  = 20;
  localparam int RESET_LIMIT = 20;

  logic      clk;
  logic      rst_n;
  // DUT inputs
  logic      csr_we;
  csr_addr_t csr_addr;
  xlen_t     csr_wdata;
  csr_addr_t csr_raddr;
  xlen_t     irq;
  logic      fetch_enable;
  logic      wfi;
  // DUT outputs
  xlen_t     csr_rdata;
  logic      irq_req;
  irq_id_t   irq_id;
  logic      core_sleep;
  logic      hart_running;
  logic      alert_minor;
  logic      alert_major;

  // Reference state that follows the DUT inputs edge by edge
  xlen_t        mie_m;
  xlen_t        mip_m;
  logic         en_m;
  logic         minor_m;
  sleep_state_e sleep_m;

  // Pending read expectation from the stimulus
  logic  rd_check;
  xlen_t rd_exp;

  int   seed;
  int   n_checks;
  int   n_errors;
  int   errors_at_start;
  logic timed_out;
  // Last values written to the CSRs
  xlen_t mie_val;
  logic  en_val;

  tb_clock_gen clock_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  hart_ctrl_top DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .csr_we_i       ( csr_we       ),
    .csr_addr_i     ( csr_addr     ),
    .csr_wdata_i    ( csr_wdata    ),
    .csr_raddr_i    ( csr_raddr    ),
    .csr_rdata_o    ( csr_rdata    ),
    .irq_i          ( irq          ),
    .irq_req_o      ( irq_req      ),
    .irq_id_o       ( irq_id       ),
    .fetch_enable_i ( fetch_enable ),
    .wfi_i          ( wfi          ),
    .core_sleep_o   ( core_sleep   ),
    .hart_running_o ( hart_running ),
    .alert_minor_o  ( alert_minor  ),
    .alert_major_o  ( alert_major  )
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Expected request and id by a scan down from the top line
  function automatic void ref_irq(input xlen_t mip, input xlen_t mie, input logic en,
                                  output logic req, output irq_id_t id);
    xlen_t pend;
    logic  found;
    pend  = mip & mie;
    req   = (pend != '0) && en;
    id    = '0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (!found && pend[i]) begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
  endfunction

  // mstatus as read back with only the enable bit kept
  function automatic xlen_t mstatus_word(input logic en);
    xlen_t w;
    w = '0;
    w[MSTATUS_MIE_BIT] = en;
    return w;
  endfunction

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR @%0t: %0s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_irq_id(input string name, input irq_id_t got, input irq_id_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR @%0t: %0s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR @%0t: %0s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Model of the CSRs and sampled lines plus minor alert and sleep state
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_m   <= '0;
      mip_m   <= '0;
      en_m    <= 1'b0;
      minor_m <= 1'b0;
      sleep_m <= SLEEP_WAIT_FETCH;
    end else begin
      mip_m   <= irq;
      minor_m <= csr_we && (csr_addr != CSR_MIE) && (csr_addr != CSR_MSTATUS);
      if (csr_we && (csr_addr == CSR_MIE)) mie_m <= csr_wdata;
      if (csr_we && (csr_addr == CSR_MSTATUS)) en_m <= csr_wdata[MSTATUS_MIE_BIT];
      case (sleep_m)
        SLEEP_WAIT_FETCH: if (fetch_enable) sleep_m <= SLEEP_RUN;
        SLEEP_RUN:        if (wfi && ((mip_m & mie_m) == '0)) sleep_m <= SLEEP_ASLEEP;
        SLEEP_ASLEEP:     if ((mip_m & mie_m) != '0) sleep_m <= SLEEP_RUN;
        default:          sleep_m <= SLEEP_WAIT_FETCH;
      endcase
    end
  end

  // Compare on the falling edge when outputs are stable
  always @(negedge clk) begin
    logic    exp_req;
    irq_id_t exp_id;
    if (rst_n) begin
      ref_irq(mip_m, mie_m, en_m, exp_req, exp_id);
      check_bit("irq_req_o", irq_req, exp_req);
      check_irq_id("irq_id_o", irq_id, exp_id);
      check_bit("alert_minor_o", alert_minor, minor_m);
      // No shadow fault is ever injected
      check_bit("alert_major_o", alert_major, 1'b0);
      check_bit("core_sleep_o", core_sleep, sleep_m == SLEEP_ASLEEP);
      check_bit("hart_running_o", hart_running, sleep_m == SLEEP_RUN);
      if (rd_check) begin
        check_word($sformatf("csr_rdata_o at %h", csr_raddr), csr_rdata, rd_exp);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic csr_write(input csr_addr_t addr, input xlen_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  // Old value before the write edge and new value right after it
  task automatic write_readback(input csr_addr_t addr, input xlen_t data,
                                input xlen_t old_exp, input xlen_t new_exp);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    csr_raddr <= addr;
    rd_exp    <= old_exp;
    rd_check  <= 1'b1;
    @(posedge clk);
    csr_we    <= 1'b0;
    rd_exp    <= new_exp;
    @(posedge clk);
    rd_check  <= 1'b0;
  endtask

  // One cycle read that the falling edge compares
  task automatic read_check(input csr_addr_t addr, input xlen_t exp);
    @(posedge clk);
    csr_raddr <= addr;
    rd_exp    <= exp;
    rd_check  <= 1'b1;
    @(posedge clk);
    rd_check  <= 1'b0;
  endtask

  task automatic read_all(input xlen_t exp_mip);
    read_check(CSR_MSTATUS, mstatus_word(en_val));
    read_check(CSR_MIE, mie_val);
    read_check(CSR_MIP, exp_mip);
  endtask

  task automatic pulse_fetch_enable;
    @(posedge clk);
    fetch_enable <= 1'b1;
    @(posedge clk);
    fetch_enable <= 1'b0;
  endtask

  task automatic pulse_wfi;
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
  endtask

  // Bounded poll of the sleep outputs on falling edges
  task automatic wait_sleep_state(input logic exp_sleep, input logic exp_run,
                                  input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (n < WAIT_LIMIT && !(core_sleep === exp_sleep && hart_running === exp_run));
    if (!(core_sleep === exp_sleep && hart_running === exp_run)) begin
      $display("Timeout while waiting for %0s", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk);
    $display("Test %0s finished with %0d errors", name, n_errors - errors_at_start);
    errors_at_start = n_errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values;
    mie_val = '0;
    en_val  = 1'b0;
    read_all('0);
    end_test("reset_values");
  endtask

  task automatic csr_readback;
    xlen_t data;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      write_readback(CSR_MIE, data, mie_val, data);
      mie_val = data;
      data = $random(seed);
      write_readback(CSR_MSTATUS, data, mstatus_word(en_val),
                     mstatus_word(data[MSTATUS_MIE_BIT]));
      en_val = data[MSTATUS_MIE_BIT];
    end
    end_test("csr_readback");
  endtask

  // irq stays 0 so mip must read 0 throughout
  task automatic illegal_writes;
    csr_addr_t addr;
    csr_write(CSR_MIP, $random(seed));
    read_all('0);
    for (int i = 0; i < 4; i++) begin
      addr = csr_addr_t'($random(seed));
      if (addr == CSR_MIE || addr == CSR_MSTATUS) addr = addr ^ 12'h001;
      csr_write(addr, $random(seed));
      read_all('0);
    end
    end_test("illegal_writes");
  endtask

  task automatic irq_select;
    xlen_t irq_val;
    for (int i = 0; i < 12; i++) begin
      mie_val = $random(seed);
      irq_val = $random(seed);
      // One round with nothing enabled
      if (i == 3) mie_val = '0;
      en_val = (i % 2 == 0);
      csr_write(CSR_MIE, mie_val);
      csr_write(CSR_MSTATUS, mstatus_word(en_val));
      @(posedge clk);
      irq <= irq_val;
      read_check(CSR_MIP, irq_val);
    end
    @(posedge clk);
    irq <= '0;
    end_test("irq_select");
  endtask

  task automatic sleep_wakeup;
    // Line 11 enabled with the global enable clear
    en_val  = 1'b0;
    mie_val = 32'h0000_0800;
    csr_write(CSR_MSTATUS, mstatus_word(en_val));
    csr_write(CSR_MIE, mie_val);
    pulse_fetch_enable();
    wait_sleep_state(1'b0, 1'b1, "hart_running_o after fetch enable");
    if (timed_out) return;
    pulse_wfi();
    wait_sleep_state(1'b1, 1'b0, "core_sleep_o after wfi");
    if (timed_out) return;
    @(posedge clk);
    irq <= 32'h0000_0800;
    wait_sleep_state(1'b0, 1'b1, "wake-up from irq line 11");
    if (timed_out) return;
    // Wake-up still pending so wfi must not sleep
    pulse_wfi();
    repeat (4) @(negedge clk);
    @(posedge clk);
    irq <= '0;
    end_test("sleep_wakeup");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    csr_we          <= 1'b0;
    csr_addr        <= CSR_MSTATUS;
    csr_wdata       <= '0;
    csr_raddr       <= CSR_MSTATUS;
    irq             <= '0;
    fetch_enable    <= 1'b0;
    wfi             <= 1'b0;
    rd_check        <= 1'b0;
    rd_exp          <= '0;
    seed            = 32'h54c1;
    n_checks        = 0;
    n_errors        = 0;
    errors_at_start = 0;
    timed_out       = 1'b0;
    mie_val         = '0;
    en_val          = 1'b0;

    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (n < RESET_LIMIT && !rst_n);
    if (!rst_n) begin
      $display("Reset was never released");
      timed_out = 1'b1;
    end

    if (!timed_out) reset_values();
    if (!timed_out) csr_readback();
    if (!timed_out) illegal_writes();
    if (!timed_out) irq_select();
    if (!timed_out) sleep_wakeup();
    repeat (2) @(posedge clk);

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Period of 8 time units
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for the first 8 rising edges
  initial begin
    rst_n_o <= 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: source/hart_ctrl_top.sv
`default_nettype none

module hart_ctrl_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // CSR access, stands in for the decoder
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  input  csr_pkg::csr_addr_t csr_raddr_i,
  output csr_pkg::xlen_t     csr_rdata_o,
  // Interrupts
  input  csr_pkg::xlen_t     irq_i,
  output logic               irq_req_o,
  output ctrl_pkg::irq_id_t  irq_id_o,
  // Run control
  input  logic               fetch_enable_i,
  input  logic               wfi_i,
  output logic               core_sleep_o,
  output logic               hart_running_o,
  // Security alerts
  output logic               alert_minor_o,
  output logic               alert_major_o
);

  import csr_pkg::*;

  // CSR block to interrupt controller
  xlen_t mie;
  logic  m_irq_enable;
  // Interrupt controller to CSR block and sleep unit
  xlen_t mip;
  logic  irq_wu;
  // Alert triggers
  logic  csr_err;
  logic  csr_illegal_wr;

  //////////////////////////////////////////////////////////////////////
  // CSRs
  //////////////////////////////////////////////////////////////////////

  csr_irq_regs csr_irq_regs_i (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .csr_we_i         ( csr_we_i       ),
    .csr_addr_i       ( csr_addr_i     ),
    .csr_wdata_i      ( csr_wdata_i    ),
    .csr_raddr_i      ( csr_raddr_i    ),
    .csr_rdata_o      ( csr_rdata_o    ),
    .mip_i            ( mip            ),
    .mie_o            ( mie            ),
    .m_irq_enable_o   ( m_irq_enable   ),
    .csr_illegal_wr_o ( csr_illegal_wr ),
    .csr_err_o        ( csr_err        )
  );

  //////////////////////////////////////////////////////////////////////
  // Interrupts and sleep
  //////////////////////////////////////////////////////////////////////

  int_controller int_controller_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .irq_i          ( irq_i        ),
    .mie_i          ( mie          ),
    .m_irq_enable_i ( m_irq_enable ),
    .mip_o          ( mip          ),
    .irq_req_o      ( irq_req_o    ),
    .irq_id_o       ( irq_id_o     ),
    .irq_wu_o       ( irq_wu       )
  );

  sleep_unit sleep_unit_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .irq_wu_i       ( irq_wu         ),
    .core_sleep_o   ( core_sleep_o   ),
    .hart_running_o ( hart_running_o )
  );

  //////////////////////////////////////////////////////////////////////
  // Alerts
  //////////////////////////////////////////////////////////////////////

  alert_unit alert_unit_i (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .csr_illegal_wr_i ( csr_illegal_wr ),
    .csr_err_i        ( csr_err        ),
    .alert_minor_o    ( alert_minor_o  ),
    .alert_major_o    ( alert_major_o  )
  );

endmodule

`default_nettype wire

// File: source/alert_unit.sv
`default_nettype none

module alert_unit (
  input  logic clk_i,
  input  logic rst_n_i,
  // Minor trigger
  input  logic csr_illegal_wr_i,
  // Major trigger
  input  logic csr_err_i,
  output logic alert_minor_o,
  output logic alert_major_o
);

  logic alert_minor_q;
  logic alert_major_q;

  // Flopped so the outputs never glitch
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alert_minor_q <= 1'b0;
      alert_major_q <= 1'b0;
    end else begin
      alert_minor_q <= csr_illegal_wr_i;
      alert_major_q <= csr_err_i;
    end
  end

  assign alert_minor_o = alert_minor_q;
  assign alert_major_o = alert_major_q;

  // Minor alert only one cycle after an illegal write
  a_minor_after_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alert_minor_o |-> $past(csr_illegal_wr_i));

endmodule

`default_nettype wire

// File: source/sleep_unit.sv
`default_nettype none

module sleep_unit (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic fetch_enable_i,
  input  logic wfi_i,
  input  logic irq_wu_i,
  output logic core_sleep_o,
  output logic hart_running_o
);

  import ctrl_pkg::*;

  sleep_state_e state_q;
  sleep_state_e state_d;
  logic         fetch_enable_q;
  logic         fetch_enable;

  // Sticky fetch enable, a single pulse is enough
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  assign fetch_enable = fetch_enable_i || fetch_enable_q;

  //////////////////////////////////////////////////////////////////////
  // Sleep FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLEEP_WAIT_FETCH: begin
        if (fetch_enable) state_d = SLEEP_RUN;
      end
      // Pending wake-up turns wfi into a no-op
      SLEEP_RUN: begin
        if (wfi_i && !irq_wu_i) state_d = SLEEP_ASLEEP;
      end
      SLEEP_ASLEEP: begin
        if (irq_wu_i) state_d = SLEEP_RUN;
      end
      default: state_d = SLEEP_WAIT_FETCH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SLEEP_WAIT_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_sleep_o   = (state_q == SLEEP_ASLEEP);
  assign hart_running_o = (state_q == SLEEP_RUN);

  a_sleep_run_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(core_sleep_o && hart_running_o));

endmodule

`default_nettype wire

// File: source/int_controller.sv
`default_nettype none

module int_controller (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // External interrupt levels
  input  csr_pkg::xlen_t   irq_i,
  // From CSR block
  input  csr_pkg::xlen_t   mie_i,
  input  logic             m_irq_enable_i,
  // Back to CSR block for reads
  output csr_pkg::xlen_t   mip_o,
  // Selected interrupt
  output logic             irq_req_o,
  output ctrl_pkg::irq_id_t irq_id_o,
  // Wake-up, ignores global enable
  output logic             irq_wu_o
);

  import csr_pkg::*;
  import ctrl_pkg::*;

  xlen_t mip_q;
  xlen_t irq_masked;

  // Sample lines every cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i;
    end
  end

  assign mip_o      = mip_q;
  assign irq_masked = mip_q & mie_i;

  assign irq_wu_o  = |irq_masked;
  assign irq_req_o = irq_wu_o && m_irq_enable_i;

  // Highest index wins, later match overrides
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (irq_masked[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  // Selected line is pending and enabled in the CSR block
  a_req_id_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_req_o |-> (mip_o[irq_id_o] && mie_i[irq_id_o]));

endmodule

`default_nettype wire

// File: source/csr_irq_regs.sv
`default_nettype none

module csr_irq_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Write port
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  // Read port
  input  csr_pkg::csr_addr_t csr_raddr_i,
  output csr_pkg::xlen_t     csr_rdata_o,
  // Interrupt state
  input  csr_pkg::xlen_t     mip_i,
  output csr_pkg::xlen_t     mie_o,
  output logic               m_irq_enable_o,
  // Alert triggers
  output logic               csr_illegal_wr_o,
  output logic               csr_err_o
);

  import csr_pkg::*;

  // Primary registers
  xlen_t mie_q;
  logic  mstatus_mie_q;
  // Inverted shadow copies
  xlen_t mie_shadow_q;
  logic  mstatus_mie_shadow_q;

  logic  mie_we;
  logic  mstatus_we;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  assign mie_we     = csr_we_i && (csr_addr_i == CSR_MIE);
  assign mstatus_we = csr_we_i && (csr_addr_i == CSR_MSTATUS);

  // mip is read-only, so it counts as illegal as well
  assign csr_illegal_wr_o = csr_we_i && !((csr_addr_i == CSR_MIE) ||
                                          (csr_addr_i == CSR_MSTATUS));

  // Register and shadow always written in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mie_q                <= '0;
      mie_shadow_q         <= '1;
      mstatus_mie_q        <= 1'b0;
      mstatus_mie_shadow_q <= 1'b1;
    end else begin
      if (mie_we) begin
        mie_q        <= csr_wdata_i;
        mie_shadow_q <= ~csr_wdata_i;
      end
      // Only the global enable bit is writable
      if (mstatus_we) begin
        mstatus_mie_q        <= csr_wdata_i[MSTATUS_MIE_BIT];
        mstatus_mie_shadow_q <= ~csr_wdata_i[MSTATUS_MIE_BIT];
      end
    end
  end

  // Any register/shadow disagreement
  assign csr_err_o = (mie_q != ~mie_shadow_q) || (mstatus_mie_q != ~mstatus_mie_shadow_q);

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_raddr_i)
      CSR_MSTATUS: csr_rdata_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
      CSR_MIE:     csr_rdata_o = mie_q;
      CSR_MIP:     csr_rdata_o = mip_i;
      default:     csr_rdata_o = '0;
    endcase
  end

  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_mie_q;

  // Shadows track their registers across every write
  a_shadow_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mie_shadow_q == ~mie_q) && (mstatus_mie_shadow_q == ~mstatus_mie_q));

  // No illegal flag without a write strobe
  a_illegal_needs_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(csr_illegal_wr_o) |-> csr_we_i);

endmodule

`default_nettype wire

// File: source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // Index of one of the 32 interrupt lines
  localparam int unsigned IRQ_ID_W = 5;

  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // Hart run state
  // Wait for fetch enable after reset, then run, sleep on wfi
  typedef enum logic [1:0] {
    SLEEP_WAIT_FETCH = 2'b00,
    SLEEP_RUN        = 2'b01,
    SLEEP_ASLEEP     = 2'b10
  } sleep_state_e;

endpackage

`default_nettype wire

// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Machine word, also used for mie and mip vectors
  localparam int unsigned XLEN       = 32;
  localparam int unsigned CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  //////////////////////////////////////////////////////////////////////
  // CSR map
  //////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  // Read-only, sampled interrupt lines
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // Global machine interrupt enable inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

endpackage

`default_nettype wire
